// File: hdl/cmd_decoder.sv
`timescale 1ns/10ps

module cmd_decoder (
    input  logic               sys_clk,
    input  logic               i_rst,
    input  logic               i_rx_valid,
    input  pci_pkg::spi_byte_t i_rx_byte,
    input  logic               i_frame_start,
    input  logic               i_rd_valid,
    input  pci_pkg::bus_data_t i_rd_data,
    output pci_pkg::spi_byte_t o_tx_byte,
    output logic               o_cmd_valid,
    output pci_pkg::cmd_op_t   o_cmd_op,
    output pci_pkg::bus_addr_t o_cmd_addr,
    output pci_pkg::bus_data_t o_cmd_data,
    output logic               o_intr
);
    import pci_pkg::*;

    dec_state_t state;
    cmd_op_t    op_reg;
    logic [1:0] byte_cnt;
    logic       op_known;
    bus_data_t  tx_reg;     // Read reply, MSB byte goes out first
    logic [1:0] tx_cnt;
    logic       rd_pending;

    always_comb begin
        case (op_reg)
            OP_WRITE, OP_READ, OP_RUN, OP_HALT: op_known = 1'b1;
            default:                            op_known = 1'b0;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (i_rst) begin
            state       <= DEC_OP;
            byte_cnt    <= '0;
            o_cmd_valid <= 1'b0;
        end else begin
            o_cmd_valid <= 1'b0;
            if (i_frame_start) begin
                state    <= DEC_OP;
                byte_cnt <= '0;
            end else if (i_rx_valid) begin
                case (state)
                    DEC_OP: begin
                        op_reg   <= cmd_op_t'(i_rx_byte);
                        byte_cnt <= '0;
                        if (i_rx_byte != OP_NOP)
                            state <= DEC_ADDR; // NOP bytes stay here
                    end
                    DEC_ADDR: begin
                        o_cmd_addr <= {o_cmd_addr[23:0], i_rx_byte};
                        byte_cnt   <= byte_cnt + 2'd1;
                        if (byte_cnt == 2'(ADDR_BYTES - 1)) begin
                            byte_cnt <= '0;
                            if (op_reg == OP_WRITE) begin
                                state <= DEC_DATA;
                            end else begin
                                o_cmd_valid <= op_known; // Unknown opcode dropped here
                                state       <= DEC_SKIP;
                            end
                        end
                    end
                    DEC_DATA: begin
                        o_cmd_data <= {o_cmd_data[23:0], i_rx_byte};
                        byte_cnt   <= byte_cnt + 2'd1;
                        if (byte_cnt == 2'(DATA_BYTES - 1)) begin
                            o_cmd_valid <= 1'b1;
                            state       <= DEC_SKIP;
                        end
                    end
                    default: state <= DEC_SKIP; // Extra bytes ignored
                endcase
            end
        end
    end

    assign o_cmd_op = op_reg;

    // Read reply queue and interrupt
    always_ff @(posedge sys_clk) begin
        if (i_rst) begin
            rd_pending <= 1'b0;
            tx_cnt     <= '0;
            o_intr     <= 1'b0;
        end else if (i_rd_valid) begin
            tx_reg     <= i_rd_data;
            rd_pending <= 1'b1;
            tx_cnt     <= '0;
            o_intr     <= 1'b1;
        end else begin
            if (i_frame_start)
                o_intr <= 1'b0;
            if (rd_pending && i_rx_valid) begin
                tx_reg <= tx_reg << 8;
                tx_cnt <= tx_cnt + 2'd1;
                if (tx_cnt == 2'(DATA_BYTES - 1))
                    rd_pending <= 1'b0; // Whole word sent
            end
        end
    end

    assign o_tx_byte = rd_pending ? tx_reg[31:24] : '0;

    ap_cmd_pulse: assert property (@(posedge sys_clk) disable iff (i_rst)
        o_cmd_valid |=> !o_cmd_valid);

endmodule

// File: hdl/cmd_executor.sv
`timescale 1ns/10ps

module cmd_executor (
    input  logic               sys_clk,
    input  logic               i_rst,
    input  logic               i_cmd_valid,
    input  pci_pkg::cmd_op_t   i_cmd_op,
    input  pci_pkg::bus_addr_t i_cmd_addr,
    input  pci_pkg::bus_data_t i_cmd_data,
    output logic               o_rd_valid,
    output pci_pkg::bus_data_t o_rd_data,
    output logic               o_rst_core,
    wb_if.master               bus
);
    import pci_pkg::*;

    always_ff @(posedge sys_clk) begin
        if (i_rst) begin
            bus.cyc    <= 1'b0;
            bus.stb    <= 1'b0;
            bus.we     <= 1'b0;
            o_rd_valid <= 1'b0;
            o_rst_core <= 1'b1; // Core held after reset
        end else begin
            o_rd_valid <= 1'b0;
            if (bus.cyc) begin
                // Commands arriving now are ignored
                if (bus.ack) begin
                    bus.cyc    <= 1'b0;
                    bus.stb    <= 1'b0;
                    o_rd_valid <= !bus.we;
                end
            end else if (i_cmd_valid) begin
                case (i_cmd_op)
                    OP_RUN:  o_rst_core <= 1'b0;
                    OP_HALT: o_rst_core <= 1'b1;
                    OP_WRITE, OP_READ: begin
                        bus.cyc <= 1'b1;
                        bus.stb <= 1'b1;
                        bus.we  <= (i_cmd_op == OP_WRITE);
                    end
                    default: ; // NOP does nothing
                endcase
            end
        end
    end

    // Address, write data and read capture
    always_ff @(posedge sys_clk) begin
        if (!bus.cyc && i_cmd_valid) begin
            bus.addr  <= i_cmd_addr;
            bus.wdata <= i_cmd_data;
        end
        if (bus.cyc && bus.ack)
            o_rd_data <= bus.rdata;
    end

    ap_stb_in_cyc: assert property (@(posedge sys_clk) disable iff (i_rst)
        bus.stb |-> bus.cyc);

endmodule

// File: hdl/pci_pkg.sv
package pci_pkg;

    // Bus widths
    typedef logic [31:0] bus_addr_t;  // Byte address
    typedef logic [31:0] bus_data_t;
    typedef logic [7:0]  spi_byte_t;
    typedef logic [7:0]  mem_index_t; // Word index, address bits 9 to 2

    localparam int MEM_WORDS  = 256;
    localparam int ADDR_BYTES = 4;    // Address bytes per frame, MSB first
    localparam int DATA_BYTES = 4;    // Data bytes, WRITE frames only

    // First byte of every frame
    typedef enum logic [7:0] {
        OP_NOP   = 8'h00,
        OP_WRITE = 8'h01,
        OP_READ  = 8'h02,
        OP_RUN   = 8'h03,
        OP_HALT  = 8'h04
    } cmd_op_t;

    // Frame parser states
    typedef enum logic [1:0] {
        DEC_OP,
        DEC_ADDR,
        DEC_DATA,
        DEC_SKIP  // Command issued or dropped, wait for next frame
    } dec_state_t;

endpackage

// File: hdl/processor_ci_top.sv
`timescale 1ns/10ps

module processor_ci_top (
    input  logic               sys_clk,
    input  logic               i_rst,

    // SPI host link
    input  logic               i_sck,
    input  logic               i_cs_n,
    input  logic               i_mosi,
    output logic               o_miso,
    output logic               o_intr,

    // Core control and data bus
    output logic               o_rst_core,
    input  logic               i_core_cyc,
    input  logic               i_core_stb,
    input  logic               i_core_we,
    input  pci_pkg::bus_addr_t i_core_addr,
    input  pci_pkg::bus_data_t i_core_data,
    output pci_pkg::bus_data_t o_core_data,
    output logic               o_core_ack
);
    import pci_pkg::*;

    logic      rx_valid;
    spi_byte_t rx_byte;
    spi_byte_t tx_byte;
    logic      frame_start;
    logic      cmd_valid;
    cmd_op_t   cmd_op;
    bus_addr_t cmd_addr;
    bus_data_t cmd_data;
    logic      rd_valid;
    bus_data_t rd_data;

    wb_if host_bus ();  // Executor to memory

    spi_byte_shifter u_spi_byte_shifter (
        .sys_clk       (sys_clk),
        .i_rst         (i_rst),
        .i_sck         (i_sck),
        .i_cs_n        (i_cs_n),
        .i_mosi        (i_mosi),
        .i_tx_byte     (tx_byte),
        .o_miso        (o_miso),
        .o_rx_valid    (rx_valid),
        .o_rx_byte     (rx_byte),
        .o_frame_start (frame_start)
    );

    cmd_decoder u_cmd_decoder (
        .sys_clk       (sys_clk),
        .i_rst         (i_rst),
        .i_rx_valid    (rx_valid),
        .i_rx_byte     (rx_byte),
        .i_frame_start (frame_start),
        .i_rd_valid    (rd_valid),
        .i_rd_data     (rd_data),
        .o_tx_byte     (tx_byte),
        .o_cmd_valid   (cmd_valid),
        .o_cmd_op      (cmd_op),
        .o_cmd_addr    (cmd_addr),
        .o_cmd_data    (cmd_data),
        .o_intr        (o_intr)
    );

    cmd_executor u_cmd_executor (
        .sys_clk       (sys_clk),
        .i_rst         (i_rst),
        .i_cmd_valid   (cmd_valid),
        .i_cmd_op      (cmd_op),
        .i_cmd_addr    (cmd_addr),
        .i_cmd_data    (cmd_data),
        .o_rd_valid    (rd_valid),
        .o_rd_data     (rd_data),
        .o_rst_core    (o_rst_core),
        .bus           (host_bus.master)
    );

    shared_mem u_shared_mem (
        .sys_clk       (sys_clk),
        .i_rst         (i_rst),
        .i_core_cyc    (i_core_cyc),
        .i_core_stb    (i_core_stb),
        .i_core_we     (i_core_we),
        .i_core_addr   (i_core_addr),
        .i_core_data   (i_core_data),
        .o_core_data   (o_core_data),
        .o_core_ack    (o_core_ack),
        .host          (host_bus.slave)
    );

endmodule

// File: hdl/shared_mem.sv
`timescale 1ns/10ps

module shared_mem (
    input  logic               sys_clk,
    input  logic               i_rst,
    input  logic               i_core_cyc,
    input  logic               i_core_stb,
    input  logic               i_core_we,
    input  pci_pkg::bus_addr_t i_core_addr,
    input  pci_pkg::bus_data_t i_core_data,
    output pci_pkg::bus_data_t o_core_data,
    output logic               o_core_ack,
    wb_if.slave                host
);
    import pci_pkg::*;

    bus_data_t  mem [MEM_WORDS];
    logic       host_req;
    logic       core_req;
    logic       grant_core;
    mem_index_t mem_idx;
    logic       mem_we;
    bus_data_t  mem_wdata;
    bus_data_t  rd_word;

    // A port with an ack in flight does not request again
    assign host_req   = host.cyc & host.stb & ~host.ack;
    assign core_req   = i_core_cyc & i_core_stb & ~o_core_ack;
    assign grant_core = core_req & ~host_req; // Host wins a tie

    always_comb begin
        if (host_req) begin
            mem_idx   = host.addr[9:2];
            mem_we    = host.we;
            mem_wdata = host.wdata;
        end else begin
            mem_idx   = i_core_addr[9:2];
            mem_we    = grant_core & i_core_we;
            mem_wdata = i_core_data;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (mem_we)
            mem[mem_idx] <= mem_wdata;
        rd_word <= mem[mem_idx];
    end

    always_ff @(posedge sys_clk) begin
        if (i_rst) begin
            host.ack   <= 1'b0;
            o_core_ack <= 1'b0;
        end else begin
            host.ack   <= host_req;
            o_core_ack <= grant_core;
        end
    end

    assign host.rdata  = rd_word;
    assign o_core_data = rd_word;

    ap_one_ack: assert property (@(posedge sys_clk) disable iff (i_rst)
        !(host.ack && o_core_ack));

endmodule

// File: hdl/spi_byte_shifter.sv
`timescale 1ns/10ps

module spi_byte_shifter (
    input  logic               sys_clk,
    input  logic               i_rst,
    input  logic               i_sck,
    input  logic               i_cs_n,
    input  logic               i_mosi,
    input  pci_pkg::spi_byte_t i_tx_byte,
    output logic               o_miso,
    output logic               o_rx_valid,
    output pci_pkg::spi_byte_t o_rx_byte,
    output logic               o_frame_start
);
    import pci_pkg::*;

    logic [1:0] sck_s;
    logic [1:0] cs_s;
    logic [1:0] mosi_s;
    logic       sck_d;     // Previous synced sck
    logic       cs_d;
    logic       sck_rise;
    logic       sck_fall;
    logic [2:0] bit_cnt;   // Rising edges seen in current byte
    spi_byte_t  rx_shift;
    spi_byte_t  tx_shift;

    // Two-flop synchronizers plus edge history
    always_ff @(posedge sys_clk) begin
        if (i_rst) begin
            sck_s  <= '0;
            cs_s   <= 2'b11;
            mosi_s <= '0;
            sck_d  <= 1'b0;
            cs_d   <= 1'b1;
        end else begin
            sck_s  <= {sck_s[0], i_sck};
            cs_s   <= {cs_s[0], i_cs_n};
            mosi_s <= {mosi_s[0], i_mosi};
            sck_d  <= sck_s[1];
            cs_d   <= cs_s[1];
        end
    end

    assign sck_rise      = sck_s[1] & ~sck_d;
    assign sck_fall      = ~sck_s[1] & sck_d;
    assign o_frame_start = ~cs_s[1] & cs_d;

    always_ff @(posedge sys_clk) begin
        if (i_rst) begin
            bit_cnt    <= '0;
            o_rx_valid <= 1'b0;
            tx_shift   <= '0;
        end else begin
            o_rx_valid <= 1'b0;
            if (cs_s[1]) begin
                bit_cnt <= '0;
            end else if (sck_rise) begin
                bit_cnt    <= bit_cnt + 3'd1;
                o_rx_valid <= (bit_cnt == 3'd7); // 8th edge completes the byte
            end

            if (o_frame_start) begin
                tx_shift <= i_tx_byte;           // First byte out before first sck
            end else if (sck_fall && !cs_s[1]) begin
                // Counter back at zero means a byte boundary
                tx_shift <= (bit_cnt == 3'd0) ? i_tx_byte : tx_shift << 1;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (sck_rise && !cs_s[1])
            rx_shift <= {rx_shift[6:0], mosi_s[1]}; // MSB first
    end

    assign o_rx_byte = rx_shift;
    assign o_miso    = tx_shift[7];

    // Bytes only complete inside a cs-low window
    ap_rx_in_frame: assert property (@(posedge sys_clk) disable iff (i_rst)
        $rose(o_rx_valid) |-> !cs_s[1]);

endmodule

// File: hdl/wb_if.sv
`timescale 1ns/10ps

interface wb_if;
    import pci_pkg::*;

    logic      cyc;   // Transaction open
    logic      stb;   // Request valid
    logic      we;    // 1 = write
    bus_addr_t addr;
    bus_data_t wdata;
    bus_data_t rdata; // Valid during ack
    logic      ack;   // One cycle

    modport master (
        output cyc, stb, we, addr, wdata,
        input  rdata, ack
    );

    modport slave (
        input  cyc, stb, we, addr, wdata,
        output rdata, ack
    );

endinterface

// File: run_sim.sh
#!/bin/sh
# Build and run the tb_top simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_top -f tb.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_top)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: tb.f
hdl/pci_pkg.sv
hdl/wb_if.sv
hdl/spi_byte_shifter.sv
hdl/cmd_decoder.sv
hdl/cmd_executor.sv
hdl/shared_mem.sv
hdl/processor_ci_top.sv
verification/tb_clk_gen.sv
verification/tb_top.sv

// File: verification/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
    output logic o_clk,
    output logic o_rst
);
    initial begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk; // 4 ns period
    end

    // Reset held over the first two rising edges
    initial begin
        o_rst = 1'b1;
        repeat (2) @(posedge o_clk);
        @(negedge o_clk);
        o_rst = 1'b0;
    end

endmodule

// File: verification/tb_top.sv
`timescale 1ns/10ps

module tb_top;
    import pci_pkg::*;

    localparam int SCK_HALF  = 6;  // sys_clk cycles per sck phase
    localparam int FRAME_GAP = 10; // cs high between frames
    localparam int N_WRITES  = 60;
    localparam int N_READS   = 20;
    localparam int N_CORE    = 10;
    localparam int N_MIXED   = 8;
    // Longest frame is 9 bytes plus cs setup, hold and gap
    localparam int FRAME_CYCLES = 9 * 8 * 2 * SCK_HALF + 2 * SCK_HALF + FRAME_GAP;
    localparam int N_FRAMES = 3 + N_WRITES + 2 * N_READS + 2 * N_CORE + 3 * N_MIXED + 3;
    localparam int CYCLE_LIMIT = N_FRAMES * FRAME_CYCLES + 8 * (2 * N_CORE + MEM_WORDS) + 1000;

    logic        clk;
    logic        rst;
    logic        sck;
    logic        cs_n;
    logic        mosi;
    logic        miso;
    logic        intr;
    logic        rst_core;
    logic        core_cyc;
    logic        core_stb;
    logic        core_we;
    bus_addr_t   core_addr;
    bus_data_t   core_wdata;
    bus_data_t   core_rdata;
    logic        core_ack;

    bus_data_t   model [MEM_WORDS];     // Expected memory contents
    logic        core_mark [MEM_WORDS]; // Core-written words of the mixed phase
    mem_index_t  written_q [$];         // Indices known to hold data
    logic [31:0] rng_state = 32'd36;
    int          cycle_cnt = 0;
    logic        host_done;

    tb_clk_gen clk_gen_i (
        .o_clk (clk),
        .o_rst (rst)
    );

    processor_ci_top processor_ci_top_i (
        .sys_clk     (clk),
        .i_rst       (rst),
        .i_sck       (sck),
        .i_cs_n      (cs_n),
        .i_mosi      (mosi),
        .o_miso      (miso),
        .o_intr      (intr),
        .o_rst_core  (rst_core),
        .i_core_cyc  (core_cyc),
        .i_core_stb  (core_stb),
        .i_core_we   (core_we),
        .i_core_addr (core_addr),
        .i_core_data (core_wdata),
        .o_core_data (core_rdata),
        .o_core_ack  (core_ack)
    );

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Random upper and lower bits around a word that holds data
    function automatic bus_addr_t pick_written_addr();
        logic [31:0] r;
        r = next_rand();
        return {r[31:10], written_q[next_rand() % written_q.size()], r[1:0]};
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_data(input bus_data_t got, input bus_data_t exp, input string name);
        if (got !== exp)
            stop_on_error($sformatf("FAILED at %0t ns: %s = 0x%08h, expected 0x%08h",
                                    $time, name, got, exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp)
            stop_on_error($sformatf("FAILED at %0t ns: %s = %b, expected %b",
                                    $time, name, got, exp));
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
            stop_on_error($sformatf("Timeout: no progress after %0d cycles", cycle_cnt));
    end

    // One byte in mode 0, entered on a falling sys_clk edge
    task automatic spi_byte(input spi_byte_t tx, output spi_byte_t rx);
        int i;
        for (i = 7; i >= 0; i--) begin
            mosi = tx[i];
            repeat (SCK_HALF) @(negedge clk);
            rx[i] = miso; // Settled long before the rising edge
            sck = 1'b1;
            repeat (SCK_HALF) @(negedge clk);
            sck = 1'b0;
        end
    endtask

    task automatic end_frame();
        repeat (SCK_HALF) @(negedge clk);
        cs_n = 1'b1;
        repeat (FRAME_GAP) @(negedge clk);
    endtask

    task automatic send_cmd(input spi_byte_t op, input bus_addr_t addr,
                            input bus_data_t data, input logic with_data);
        spi_byte_t unused;
        int        k;
        @(negedge clk);
        cs_n = 1'b0;
        spi_byte(op, unused);
        for (k = ADDR_BYTES - 1; k >= 0; k--)
            spi_byte(addr[8*k +: 8], unused);
        if (with_data) begin
            for (k = DATA_BYTES - 1; k >= 0; k--)
                spi_byte(data[8*k +: 8], unused);
        end
        end_frame();
    endtask

    task automatic host_write(input bus_addr_t addr, input bus_data_t data);
        send_cmd(OP_WRITE, addr, data, 1'b1);
        model[addr[9:2]] = data;
        written_q.push_back(addr[9:2]);
    endtask

    task automatic host_read(input bus_addr_t addr);
        bus_data_t got;
        spi_byte_t b;
        int        k;
        send_cmd(OP_READ, addr, '0, 1'b0);
        while (!intr)
            @(negedge clk); // Bounded by the cycle limit
        @(negedge clk);
        cs_n = 1'b0;
        for (k = DATA_BYTES - 1; k >= 0; k--) begin
            spi_byte(OP_NOP, b);
            got[8*k +: 8] = b;
        end
        end_frame();
        check_bit(intr, 1'b0, "o_intr");
        check_data(got, model[addr[9:2]], "o_miso word");
    endtask

    task automatic core_access(input logic we, input bus_addr_t addr,
                               input bus_data_t wdata, output bus_data_t rdata);
        @(negedge clk);
        core_cyc   = 1'b1;
        core_stb   = 1'b1;
        core_we    = we;
        core_addr  = addr;
        core_wdata = wdata;
        @(negedge clk);
        while (!core_ack)
            @(negedge clk);
        rdata    = core_rdata; // Valid during ack
        core_cyc = 1'b0;
        core_stb = 1'b0;
    endtask

    task automatic core_write(input bus_addr_t addr, input bus_data_t data);
        bus_data_t unused;
        core_access(1'b1, addr, data, unused);
        model[addr[9:2]] = data;
        written_q.push_back(addr[9:2]);
    endtask

    task automatic core_read(input bus_addr_t addr);
        bus_data_t got;
        core_access(1'b0, addr, '0, got);
        check_data(got, model[addr[9:2]], "o_core_data");
    endtask

    initial begin
        bus_addr_t addr;
        bus_data_t data;
        bus_data_t keep;
        bus_addr_t c_addr;
        bus_data_t c_data;
        bus_addr_t core_q [$];
        bus_addr_t mixed_q [$];
        int        n;
        int        m;

        sck        = 1'b0;
        cs_n       = 1'b1;
        mosi       = 1'b0;
        core_cyc   = 1'b0;
        core_stb   = 1'b0;
        core_we    = 1'b0;
        core_addr  = '0;
        core_wdata = '0;
        host_done  = 1'b0;
        for (n = 0; n < MEM_WORDS; n++)
            core_mark[n] = 1'b0;
        @(negedge rst);
        @(negedge clk);

        // State after reset, then core reset control
        check_bit(rst_core, 1'b1, "o_rst_core");
        check_bit(intr, 1'b0, "o_intr");
        check_bit(miso, 1'b0, "o_miso");
        check_bit(core_ack, 1'b0, "o_core_ack");
        send_cmd(OP_RUN, '0, '0, 1'b0);
        check_bit(rst_core, 1'b0, "o_rst_core");
        send_cmd(OP_HALT, '0, '0, 1'b0);
        check_bit(rst_core, 1'b1, "o_rst_core");

        for (n = 0; n < N_WRITES; n++) begin
            addr = next_rand();
            data = next_rand();
            host_write(addr, data);
        end
        for (n = 0; n < N_READS; n++)
            host_read(pick_written_addr());

        // Core sees host data, host sees core data
        send_cmd(OP_RUN, '0, '0, 1'b0);
        check_bit(rst_core, 1'b0, "o_rst_core");
        for (n = 0; n < N_CORE; n++)
            core_read(pick_written_addr());
        for (n = 0; n < N_CORE; n++) begin
            addr = next_rand();
            data = next_rand();
            core_write(addr, data);
            core_q.push_back(addr);
        end
        foreach (core_q[i])
            host_read(core_q[i]);

        // Host on even words, core on odd words, at the same time
        fork
            begin
                for (n = 0; n < N_MIXED; n++) begin
                    addr = next_rand() & ~32'h4;
                    data = next_rand();
                    host_write(addr, data);
                    mixed_q.push_back(addr);
                end
                host_done = 1'b1;
            end
            begin
                while (!host_done) begin
                    c_addr = next_rand() | 32'h4;
                    c_data = next_rand();
                    core_write(c_addr, c_data);
                    core_mark[c_addr[9:2]] = 1'b1;
                    repeat (next_rand() % 8) @(negedge clk); // Vary phase against frames
                end
            end
        join
        foreach (mixed_q[i])
            host_read(mixed_q[i]);
        for (m = 0; m < MEM_WORDS; m++) begin
            if (core_mark[m])
                core_read({22'h0, 8'(m), 2'b00});
        end

        // Unknown opcode must leave memory alone
        addr = pick_written_addr();
        keep = model[addr[9:2]];
        send_cmd(8'h5A, addr, ~keep, 1'b1);
        host_read(addr);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
